// File: Makefile
# Verilator build and run for the control-input testbench

VERILATOR ?= verilator
TOP ?= tb_arkanoid_ctrl
OBJ_DIR ?= obj_dir
FILELIST ?= build.f
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
design/arkanoid_ctrl_pkg.sv
design/key_decoder.sv
design/dip_loader.sv
design/spin_accum.sv
design/quad_phase_gen.sv
design/ctrl_output.sv
design/arkanoid_ctrl_top.sv
dv/arkanoid_ctrl_checker.sv
dv/tb_arkanoid_ctrl.sv

// File: design/arkanoid_ctrl_pkg.sv
// Shared types and constants for the paddle-game control-input subsystem
// Event structs for key, mouse and download strobes, cabinet button bundles,
// the quadrature phase enum and the PS/2 set-2 key codes
// Imported by every design block and by the bound checker
package arkanoid_ctrl_pkg;

	// Quadrature phase, value is the raw {A,B} pin pair
	// Forward order 11 -> 01 -> 00 -> 10 -> 11
	typedef enum logic [1:0] {
		PH_11 = 2'b11,
		PH_10 = 2'b10,
		PH_00 = 2'b00,
		PH_01 = 2'b01
	} quad_phase_e;

	typedef struct packed {
		logic pressed; // 1 = make, 0 = break
		logic [7:0] code; // Set-2 scan code
	} ps2_key_t;

	typedef struct packed {
		logic [1:0] btn; // Mouse buttons, held
		logic signed [8:0] dx; // Horizontal movement since last report
	} mouse_ev_t;

	typedef struct packed {
		logic [7:0] index; // Download slot
		logic [7:0] addr;
		logic [7:0] data;
	} dl_word_t;

	// Held buttons, active high inside the design, shot in bit 0
	typedef struct packed {
		logic service; // Bit 8
		logic coin2;
		logic coin1;
		logic start2;
		logic start1;
		logic right;
		logic left;
		logic fast;
		logic shot;
	} cab_btn_t;

	// Cabinet inputs as the board sees them, active low
	typedef struct packed {
		logic shot_n;
		logic start1_n;
		logic start2_n;
		logic coin1_n;
		logic coin2_n;
		logic service_n;
		logic tilt_n;
	} cab_out_t;

	////////////////////
	// Key codes
	localparam logic [7:0] KEY_START1 = 8'h16; // 1
	localparam logic [7:0] KEY_START2 = 8'h1E; // 2
	localparam logic [7:0] KEY_COIN1 = 8'h2E; // 5
	localparam logic [7:0] KEY_COIN2 = 8'h36; // 6
	localparam logic [7:0] KEY_SERVICE = 8'h46; // 9
	localparam logic [7:0] KEY_FAST = 8'h11; // Alt
	localparam logic [7:0] KEY_LEFT = 8'h6B; // Cursor left
	localparam logic [7:0] KEY_RIGHT = 8'h74; // Cursor right
	localparam logic [7:0] KEY_FIRE = 8'h29; // Space

	localparam logic [7:0] DIP_INDEX = 8'd254; // Download slot of the DIP byte
	localparam int POS_W = 12; // Spinner position width
	localparam int STEP_SLOW = 4; // Key-repeat load per poll
	localparam int STEP_FAST = 9; // Same, fast key held

	// One quadrature step from ph, forward or reverse
	function automatic quad_phase_e quad_step(input quad_phase_e ph, input logic fwd);
		case (ph)
			PH_11: quad_step = fwd ? PH_01 : PH_10;
			PH_01: quad_step = fwd ? PH_00 : PH_11;
			PH_00: quad_step = fwd ? PH_10 : PH_01;
			PH_10: quad_step = fwd ? PH_11 : PH_00;
			default: quad_step = PH_11; // Never hit, all four covered
		endcase
	endfunction

endpackage

// File: design/arkanoid_ctrl_top.sv
// Control-input subsystem top level
// Wires keyboard, mouse, download and encoder inputs through the decoder,
// DIP loader, spinner emulation and output stage; TICK_DIV and POLL_DIV
// set the drain rate and key-repeat rate in clock cycles
`timescale 1ns/1ns

module arkanoid_ctrl_top #(
	parameter int TICK_DIV = 3000, // 4 kHz drain at 12 MHz
	parameter int POLL_DIV = 96000 // 125 Hz key repeat
) (
	input logic CLK_12M,
	input logic rst,
	input logic key_stb,
	input arkanoid_ctrl_pkg::ps2_key_t key,
	input logic mouse_stb,
	input arkanoid_ctrl_pkg::mouse_ev_t mouse,
	input logic dl_wr,
	input arkanoid_ctrl_pkg::dl_word_t dl,
	input logic [1:0] enc_pins,
	input logic fire_pin_n,
	output arkanoid_ctrl_pkg::cab_out_t cab_out,
	output arkanoid_ctrl_pkg::quad_phase_e spinner,
	output logic [7:0] dip_n
);

	import arkanoid_ctrl_pkg::*;

	cab_btn_t btn; // Held keyboard buttons
	logic step;
	logic step_dir;
	logic emu_active;
	quad_phase_e emu_phase;
	logic [1:0] mouse_btn; // Last reported mouse buttons

	// Mouse buttons only valid with the strobe, hold between reports
	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			mouse_btn <= 2'b00;
		end else if (mouse_stb) begin
			mouse_btn <= mouse.btn;
		end
	end

	////////////////////
	// Blocks
	key_decoder u_key_decoder (
		.CLK_12M(CLK_12M), .rst(rst), .key_stb(key_stb), .key(key), .btn(btn)
	);

	dip_loader u_dip_loader (
		.CLK_12M(CLK_12M), .rst(rst), .dl_wr(dl_wr), .dl(dl), .dip_n(dip_n)
	);

	spin_accum #(.TICK_DIV(TICK_DIV), .POLL_DIV(POLL_DIV)) u_spin_accum (
		.CLK_12M(CLK_12M), .rst(rst), .mouse_stb(mouse_stb), .mouse(mouse),
		.btn(btn), .step(step), .step_dir(step_dir), .emu_active(emu_active)
	);

	quad_phase_gen u_quad_phase_gen (
		.CLK_12M(CLK_12M), .rst(rst), .step(step), .step_dir(step_dir),
		.emu_phase(emu_phase)
	);

	ctrl_output u_ctrl_output (
		.CLK_12M(CLK_12M), .rst(rst), .enc_pins(enc_pins), .fire_pin_n(fire_pin_n),
		.btn(btn), .mouse_btn(mouse_btn), .emu_phase(emu_phase),
		.emu_active(emu_active), .spinner(spinner), .cab_out(cab_out)
	);

endmodule

// File: design/ctrl_output.sv
// Cabinet output stage
// Tracks a physical quadrature encoder, picks between it and the emulated
// phase, and registers the spinner and the active-low button lines
// Raw mode is entered on any encoder pin change, left on emulated activity
`timescale 1ns/1ns

module ctrl_output (
	input logic CLK_12M,
	input logic rst,
	input logic [1:0] enc_pins, // Physical encoder {B,A}
	input logic fire_pin_n, // Physical fire button, active low
	input arkanoid_ctrl_pkg::cab_btn_t btn,
	input logic [1:0] mouse_btn, // Held mouse buttons
	input arkanoid_ctrl_pkg::quad_phase_e emu_phase,
	input logic emu_active,
	output arkanoid_ctrl_pkg::quad_phase_e spinner,
	output arkanoid_ctrl_pkg::cab_out_t cab_out
);

	import arkanoid_ctrl_pkg::*;

	logic [1:0] enc_q; // Pins one cycle ago
	logic raw_mode; // 1 = follow the physical encoder
	logic enc_fwd;
	logic fire;
	quad_phase_e raw_phase;

	assign enc_fwd = enc_pins[0] ^ enc_pins[1]; // Pins differ, forward
	assign fire = btn.shot | (|mouse_btn) | ~fire_pin_n;

	// Encoder pin history for edge detect
	always_ff @(posedge CLK_12M) begin
		enc_q <= enc_pins;
	end

	////////////////////
	// Encoder follower
	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			raw_mode <= 1'b0;
			raw_phase <= PH_11;
		end else begin
			if (emu_active) raw_mode <= 1'b0;
			if (enc_q != enc_pins) raw_mode <= 1'b1; // Pin activity wins
			// Only A edges count (half the encoder resolution)
			if (enc_q[0] != enc_pins[0]) begin
				raw_phase <= quad_step(raw_phase, enc_fwd);
			end
		end
	end

	////////////////////
	// Registered board outputs
	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			spinner <= PH_11;
			cab_out <= '1; // Everything released
		end else begin
			spinner <= raw_mode ? raw_phase : emu_phase;
			cab_out.shot_n <= ~fire;
			cab_out.start1_n <= ~btn.start1;
			cab_out.start2_n <= ~btn.start2;
			cab_out.coin1_n <= ~btn.coin1;
			cab_out.coin2_n <= ~btn.coin2;
			cab_out.service_n <= ~btn.service;
			cab_out.tilt_n <= 1'b1; // No tilt switch
		end
	end

endmodule

// File: design/dip_loader.sv
// DIP switch byte loader
// Picks the switch byte out of the download stream (slot 254, address 0)
// and presents it inverted, the board reads the switches active low
`timescale 1ns/1ns

module dip_loader (
	input logic CLK_12M,
	input logic rst,
	input logic dl_wr, // Download write strobe
	input arkanoid_ctrl_pkg::dl_word_t dl,
	output logic [7:0] dip_n // To the board, active low
);

	import arkanoid_ctrl_pkg::*;

	logic hit; // This write targets the switch byte

	// Only the first byte of the DIP slot matters
	assign hit = dl_wr && (dl.index == DIP_INDEX) && (dl.addr == 8'd0);

	////////////////////
	// Switch register
	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			dip_n <= 8'hFF; // All switches off
		end else if (hit) begin
			dip_n <= ~dl.data; // Invert toward the board
		end
	end

endmodule

// File: design/key_decoder.sv
// Keyboard button decoder
// Each key strobe carries one make or break code; the matching cabinet
// button follows the pressed bit and holds until the opposite event
// Buttons update on the clock edge after the strobe
`timescale 1ns/1ns

module key_decoder (
	input logic CLK_12M,
	input logic rst,
	input logic key_stb, // One cycle per key event
	input arkanoid_ctrl_pkg::ps2_key_t key,
	output arkanoid_ctrl_pkg::cab_btn_t btn
);

	import arkanoid_ctrl_pkg::*;

	////////////////////
	// Held button states
	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			btn <= '0; // Nothing held
		end else if (key_stb) begin
			case (key.code)
				KEY_START1: begin
					btn.start1 <= key.pressed;
				end
				KEY_START2: begin
					btn.start2 <= key.pressed;
				end
				KEY_COIN1: begin
					btn.coin1 <= key.pressed;
				end
				KEY_COIN2: begin
					btn.coin2 <= key.pressed;
				end
				KEY_SERVICE: begin
					btn.service <= key.pressed;
				end
				KEY_FAST: begin
					btn.fast <= key.pressed; // Spinner speed-up
				end
				KEY_LEFT: begin
					btn.left <= key.pressed; // Paddle left
				end
				KEY_RIGHT: begin
					btn.right <= key.pressed; // Paddle right
				end
				KEY_FIRE: begin
					btn.shot <= key.pressed;
				end
				default: begin
					// Any other key, hold state
				end
			endcase
		end
	end

endmodule

// File: design/quad_phase_gen.sv
// Emulated quadrature phase generator
// Four-state machine over the spinner phase; each drain step moves it one
// position forward or back, so successive phases differ in a single bit
// The phase changes on the edge after the step strobe
`timescale 1ns/1ns

module quad_phase_gen (
	input logic CLK_12M,
	input logic rst,
	input logic step, // Advance strobe
	input logic step_dir, // 1 = forward
	output arkanoid_ctrl_pkg::quad_phase_e emu_phase
);

	import arkanoid_ctrl_pkg::*;

	quad_phase_e next_phase;

	////////////////////
	// Next state
	always_comb begin
		if (step) begin
			next_phase = quad_step(emu_phase, step_dir);
		end else begin
			next_phase = emu_phase; // Hold between steps
		end
	end

	////////////////////
	// State register
	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			emu_phase <= PH_11; // Both pins high at rest
		end else begin
			emu_phase <= next_phase;
		end
	end

endmodule

// File: design/spin_accum.sv
// Emulated spinner position accumulator
// Mouse movement adds to a signed position, held left/right keys reload it
// once per poll period; a slow tick drains it one unit toward zero and
// emits a step strobe with the drain direction for the phase generator
`timescale 1ns/1ns

module spin_accum #(
	parameter int TICK_DIV = 3000, // Cycles per drain tick
	parameter int POLL_DIV = 96000 // Cycles per key-repeat poll
) (
	input logic CLK_12M,
	input logic rst,
	input logic mouse_stb, // One cycle per mouse report
	input arkanoid_ctrl_pkg::mouse_ev_t mouse,
	input arkanoid_ctrl_pkg::cab_btn_t btn,
	output logic step, // One drain step this cycle
	output logic step_dir, // 1 = forward
	output logic emu_active // Mouse or key activity
);

	import arkanoid_ctrl_pkg::*;

	localparam int TW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam int PW = (POLL_DIV > 1) ? $clog2(POLL_DIV) : 1;

	logic [TW-1:0] tick_cnt; // Drain tick divider
	logic [PW-1:0] poll_cnt; // Key-repeat poll counter
	logic signed [POS_W-1:0] pos; // Steps still owed, sign = direction
	logic signed [POS_W-1:0] dx_ext; // Mouse dx, sign extended
	logic signed [POS_W-1:0] step_mag; // Key-repeat magnitude
	logic signed [POS_W-1:0] key_load; // Key-repeat load value

	logic tick;
	logic key_held;
	logic poll_load;
	logic mouse_add;
	logic drain;

	////////////////////
	// Event decode
	assign tick = (tick_cnt == TW'(TICK_DIV - 1));
	assign key_held = btn.left | btn.right;
	assign poll_load = key_held && (poll_cnt == PW'(POLL_DIV - 1));

	// Top two bits equal means there is headroom for another report
	assign mouse_add = mouse_stb && (pos[POS_W-1] == pos[POS_W-2]);

	// Drain only if nothing else writes the position this cycle
	assign drain = tick && (pos != '0) && !mouse_add && !poll_load;

	assign dx_ext = {{(POS_W - 9){mouse.dx[8]}}, mouse.dx};
	assign step_mag = btn.fast ? POS_W'(STEP_FAST) : POS_W'(STEP_SLOW);
	assign key_load = btn.right ? step_mag : -step_mag; // Right wins if both held

	////////////////////
	// Counters and position
	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			tick_cnt <= '0;
			poll_cnt <= '0;
			pos <= '0;
		end else begin
			// Free-running tick
			if (tick) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end

			// Poll counter idles at zero with no key held
			if (!key_held || poll_load) begin
				poll_cnt <= '0;
			end else begin
				poll_cnt <= poll_cnt + 1'b1;
			end

			if (poll_load) begin
				pos <= key_load; // Reload, not add
			end else if (mouse_add) begin
				pos <= pos + dx_ext;
			end else if (drain) begin
				if (pos[POS_W-1]) begin
					pos <= pos + 1'b1; // Negative, up toward zero
				end else begin
					pos <= pos - 1'b1;
				end
			end
		end
	end

	////////////////////
	// Outputs
	assign step = drain;
	assign step_dir = ~pos[POS_W-1]; // Positive drains forward
	assign emu_active = mouse_stb | poll_load;

endmodule

// File: dv/arkanoid_ctrl_checker.sv
// Bound assertions on the control-input top level
// Covers reset values, button latency, DIP byte capture and the
// single-bit spinner rule while the emulated source stays selected
`timescale 1ns/1ns

module arkanoid_ctrl_checker (
	input logic CLK_12M,
	input logic rst,
	input logic key_stb,
	input arkanoid_ctrl_pkg::ps2_key_t key,
	input logic mouse_stb,
	input logic dl_wr,
	input arkanoid_ctrl_pkg::dl_word_t dl,
	input logic [1:0] enc_pins,
	input logic fire_pin_n,
	input arkanoid_ctrl_pkg::cab_out_t cab_out,
	input arkanoid_ctrl_pkg::quad_phase_e spinner,
	input logic [7:0] dip_n
);

	import arkanoid_ctrl_pkg::*;

	logic [1:0] enc_d; // Pins one cycle ago
	logic [3:0] sw_hist; // Recent spinner source switches
	logic dip_hit;
	int fail_cnt = 0; // Assertion failures so far

	assign dip_hit = dl_wr && (dl.index == DIP_INDEX) && (dl.addr == 8'd0);

	always_ff @(posedge CLK_12M) begin
		enc_d <= enc_pins;
		sw_hist <= {sw_hist[2:0], mouse_stb | (enc_d != enc_pins)};
	end

	task automatic flag_error(input string msg);
		$error("%s", msg);
		fail_cnt++;
	endtask

	////////////////////
	// Reset values, first cycle out of reset
	assert property (@(posedge CLK_12M) $fell(rst) |->
		(cab_out == '1) && (spinner == PH_11) && (dip_n == 8'hFF))
		else flag_error("reset values wrong");

	// Key to cabinet line, two cycles
	assert property (@(posedge CLK_12M) disable iff (rst)
		key_stb && (key.code == KEY_START1) |->
		##2 (cab_out.start1_n == !$past(key.pressed, 2)))
		else flag_error("start1 latency");
	assert property (@(posedge CLK_12M) disable iff (rst)
		key_stb && (key.code == KEY_COIN1) |->
		##2 (cab_out.coin1_n == !$past(key.pressed, 2)))
		else flag_error("coin1 latency");

	////////////////////
	// DIP byte
	assert property (@(posedge CLK_12M) disable iff (rst)
		dip_hit |=> (dip_n == ~$past(dl.data)))
		else flag_error("dip byte not captured");
	assert property (@(posedge CLK_12M) disable iff (rst)
		dl_wr && !dip_hit |=> $stable(dip_n))
		else flag_error("dip byte changed by other write");

	////////////////////
	// Spinner and fire
	assert property (@(posedge CLK_12M) disable iff (rst)
		(spinner != $past(spinner)) && (sw_hist == 4'b0000) |->
		$onehot(spinner ^ $past(spinner)))
		else flag_error("spinner jumped more than one bit");
	assert property (@(posedge CLK_12M) disable iff (rst) !fire_pin_n |=> !cab_out.shot_n)
		else flag_error("fire pin ignored");

endmodule

bind arkanoid_ctrl_top arkanoid_ctrl_checker u_checker (
	.CLK_12M(CLK_12M), .rst(rst), .key_stb(key_stb), .key(key), .mouse_stb(mouse_stb),
	.dl_wr(dl_wr), .dl(dl), .enc_pins(enc_pins), .fire_pin_n(fire_pin_n),
	.cab_out(cab_out), .spinner(spinner), .dip_n(dip_n)
);

// File: dv/tb_arkanoid_ctrl.sv
// Testbench for the control-input top level
// Runs reset, buttons, DIP, mouse, key repeat and encoder tests in order
// and counts spinner steps on its own from the quadrature order
`timescale 1ns/1ns

module tb_arkanoid_ctrl;

	import arkanoid_ctrl_pkg::*;

	logic CLK_12M, rst, key_stb, mouse_stb, dl_wr, fire_pin_n;
	ps2_key_t key;
	mouse_ev_t mouse;
	dl_word_t dl;
	logic [1:0] enc_pins;
	cab_out_t cab_out;
	quad_phase_e spinner;
	logic [7:0] dip_n;

	logic [31:0] lfsr = 32'ha37d;
	int errors = 0, tests = 0, failed = 0, err0 = 0;
	int fwd_cnt = 0, rev_cnt = 0; // Steps seen on spinner
	logic [1:0] prev_spin = 2'b11;

	arkanoid_ctrl_top #(.TICK_DIV(8), .POLL_DIV(64)) u_dut (.*);

	initial begin
		CLK_12M = 1'b0;
		forever #50 CLK_12M = ~CLK_12M;
	end

	initial begin // Watchdog
		repeat (200000) @(posedge CLK_12M);
		$display("Simulation ran too long, stopping");
		$display("RESULT: FAIL");
		$finish;
	end

	// Quadrature order 11 01 00 10
	function automatic logic [1:0] fwd_of(input logic [1:0] p);
		case (p)
			2'b11: fwd_of = 2'b01;
			2'b01: fwd_of = 2'b00;
			2'b00: fwd_of = 2'b10;
			default: fwd_of = 2'b11;
		endcase
	endfunction

	function automatic logic [1:0] rev_of(input logic [1:0] p);
		case (p)
			2'b11: rev_of = 2'b10;
			2'b10: rev_of = 2'b00;
			2'b00: rev_of = 2'b01;
			default: rev_of = 2'b11;
		endcase
	endfunction

	always @(negedge CLK_12M) begin
		if (spinner != prev_spin) begin
			if (spinner == fwd_of(prev_spin)) fwd_cnt++;
			else if (spinner == rev_of(prev_spin)) rev_cnt++;
		end
		prev_spin = spinner;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		repeat (n) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("CHECK FAILED at %0t: %s", $time, msg);
			errors++;
		end
	endtask

	// Own checks plus the bound assertions
	function automatic int total_errors();
		return errors + u_dut.u_checker.fail_cnt;
	endfunction

	task automatic end_test(input string name);
		int total;
		total = total_errors();
		tests++;
		if (total > err0) failed++;
		$display("test %s: %s", name, (total > err0) ? "failed" : "ok");
		err0 = total;
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		@(posedge CLK_12M);
		key_stb <= 1'b1;
		key <= '{pressed: pressed, code: code};
		@(posedge CLK_12M);
		key_stb <= 1'b0;
	endtask

	task automatic mouse_move(input int d);
		@(posedge CLK_12M);
		mouse_stb <= 1'b1;
		mouse <= '{btn: 2'b00, dx: 9'(d)};
		@(posedge CLK_12M);
		mouse_stb <= 1'b0;
	endtask

	task automatic dl_write(input logic [7:0] idx, input logic [7:0] a, input logic [7:0] d);
		@(posedge CLK_12M);
		dl_wr <= 1'b1;
		dl <= '{index: idx, addr: a, data: d};
		@(posedge CLK_12M);
		dl_wr <= 1'b0;
		@(negedge CLK_12M);
	endtask

	// Spinner quiet for 40 cycles
	task automatic wait_idle();
		int quiet, n, last;
		quiet = 0;
		n = 0;
		last = fwd_cnt + rev_cnt;
		while (quiet < 40 && n < 4000) begin
			@(posedge CLK_12M);
			n++;
			if (fwd_cnt + rev_cnt != last) begin
				quiet = 0;
				last = fwd_cnt + rev_cnt;
			end else quiet++;
		end
		if (n >= 4000) begin
			$display("Spinner never came to rest");
			errors++;
		end
	endtask

	task automatic wait_step(input int base);
		int n;
		n = 0;
		while (fwd_cnt + rev_cnt == base && n < 500) begin
			@(posedge CLK_12M);
			n++;
		end
		if (n >= 500) begin
			$display("No spinner step after key hold");
			errors++;
		end
	endtask

	// One poll load, then release, count the drain
	task automatic repeat_once(input logic [7:0] code, input int ef, input int er);
		int f0, r0;
		f0 = fwd_cnt;
		r0 = rev_cnt;
		key_event(code, 1'b1);
		wait_step(f0 + r0);
		key_event(code, 1'b0);
		wait_idle();
		check(fwd_cnt - f0 == ef && rev_cnt - r0 == er, "key repeat step count");
	endtask

	task automatic hold_key(input logic [7:0] code, input logic fwd);
		int f0, r0;
		f0 = fwd_cnt;
		r0 = rev_cnt;
		key_event(code, 1'b1);
		repeat (300) @(posedge CLK_12M);
		key_event(code, 1'b0);
		wait_idle();
		if (fwd) check(fwd_cnt > f0 && rev_cnt == r0, "right hold direction");
		else check(rev_cnt > r0 && fwd_cnt == f0, "left hold direction");
	endtask

	initial begin
		logic [7:0] codes [6];
		int bits [6]; // cab_out bit per key
		logic [31:0] v;
		logic [1:0] raw_exp, emu_exp, pins;
		logic [1:0] seq [5];
		cab_out_t snap;
		int d, f0, r0;
		logic known;

		codes = '{KEY_START1, KEY_START2, KEY_COIN1, KEY_COIN2,
			KEY_SERVICE, KEY_FIRE};
		bits = '{5, 4, 3, 2, 1, 6};
		seq = '{2'b10, 2'b00, 2'b01, 2'b00, 2'b10}; // Encoder pins {B,A}
		rst = 1'b1;
		key_stb = 1'b0;
		key = '0;
		mouse_stb = 1'b0;
		mouse = '0;
		dl_wr = 1'b0;
		dl = '0;
		enc_pins = 2'b11;
		fire_pin_n = 1'b1;
		repeat (16) @(posedge CLK_12M);
		rst <= 1'b0;
		@(negedge CLK_12M);
		check(cab_out == '1 && spinner == PH_11 && dip_n == 8'hFF, "reset values");
		end_test("reset");

		for (int i = 0; i < 6; i++) begin
			key_event(codes[i], 1'b1);
			@(posedge CLK_12M);
			@(negedge CLK_12M);
			check(cab_out == cab_out_t'(~(7'b1 << bits[i])), "button press");
			key_event(codes[i], 1'b0);
			@(posedge CLK_12M);
			@(negedge CLK_12M);
			check(cab_out == '1, "button release");
		end
		do begin
			v = rand_bits(8);
			known = 1'b0;
			foreach (codes[i]) if (v[7:0] == codes[i]) known = 1'b1;
			if (v[7:0] inside {KEY_FAST, KEY_LEFT, KEY_RIGHT}) known = 1'b1;
		end while (known);
		snap = cab_out;
		key_event(v[7:0], 1'b1);
		@(posedge CLK_12M);
		@(negedge CLK_12M);
		check(cab_out == snap, "unknown code changed outputs");
		end_test("buttons");

		v = rand_bits(8);
		dl_write(8'd254, 8'd0, v[7:0]);
		check(dip_n == ~v[7:0], "dip byte");
		dl_write(8'd253, 8'd0, ~v[7:0]);
		dl_write(8'd254, 8'd1, ~v[7:0]);
		check(dip_n == ~v[7:0], "dip byte after ignored writes");
		end_test("dip");

		repeat (2) begin
			v = rand_bits(7);
			d = int'(v % 100) + 1;
			f0 = fwd_cnt;
			r0 = rev_cnt;
			mouse_move(d);
			wait_idle();
			check(fwd_cnt - f0 == d && rev_cnt == r0, "mouse forward steps");
			mouse_move(-d);
			wait_idle();
			check(rev_cnt - r0 == d && fwd_cnt - f0 == d, "mouse reverse steps");
		end
		end_test("mouse");

		repeat_once(KEY_RIGHT, 4, 0);
		repeat_once(KEY_LEFT, 0, 4);
		key_event(KEY_FAST, 1'b1);
		repeat_once(KEY_RIGHT, 9, 0);
		key_event(KEY_FAST, 1'b0);
		hold_key(KEY_RIGHT, 1'b1);
		hold_key(KEY_LEFT, 1'b0);
		end_test("key_repeat");

		emu_exp = spinner;
		raw_exp = 2'b11;
		pins = 2'b11;
		foreach (seq[i]) begin
			if (seq[i][0] != pins[0]) begin
				// A edge, forward when the pins differ
				raw_exp = (seq[i][0] ^ seq[i][1]) ? fwd_of(raw_exp) : rev_of(raw_exp);
			end
			pins = seq[i];
			@(posedge CLK_12M);
			enc_pins <= seq[i];
			repeat (3) @(posedge CLK_12M);
			@(negedge CLK_12M);
			check(spinner == raw_exp, "raw encoder phase");
		end
		mouse_move(2);
		wait_idle();
		@(negedge CLK_12M);
		check(spinner == fwd_of(fwd_of(emu_exp)), "back to emulated phase");
		@(posedge CLK_12M);
		fire_pin_n <= 1'b0;
		repeat (2) @(posedge CLK_12M);
		@(negedge CLK_12M);
		check(!cab_out.shot_n, "fire pin to shot");
		@(posedge CLK_12M);
		fire_pin_n <= 1'b1;
		end_test("encoder");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, total_errors());
		if (total_errors() == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
